// File: rtl/adc_types_pkg.sv
`default_nettype none

package adc_types_pkg;

   // one sample from the converter pins or the test counter
   localparam int ADC_WIDTH = 12;

   // pwm increment, also the gain register width
   localparam int GAIN_WIDTH = 8;

   localparam int LED_SEL_WIDTH = 2;  // four led modes

   // a sample or a trigger level, same width on purpose
   typedef logic [ADC_WIDTH-1:0] adc_sample_t;

   typedef logic [GAIN_WIDTH-1:0] gain_t;

   typedef logic [LED_SEL_WIDTH-1:0] led_sel_t;

endpackage

`default_nettype wire

// File: rtl/adc_regmap_pkg.sv
`default_nettype none

package adc_regmap_pkg;

   localparam int REG_ADDR_WIDTH = 8;
   localparam int REG_DATA_WIDTH = 8;

   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;

   // register addresses
   localparam reg_addr_t REG_GAIN     = 8'h00;
   localparam reg_addr_t REG_SETTINGS = 8'h01;
   localparam reg_addr_t REG_TRIG_LO  = 8'h02;
   localparam reg_addr_t REG_TRIG_HI  = 8'h03;
   localparam reg_addr_t REG_STATUS   = 8'h04;  // read only

   // settings byte fields
   localparam int SET_ARM_BIT = 0;
   localparam int SET_SRC_BIT = 1;  // 1 = adc pins, 0 = test counter
   localparam int SET_LED_LSB = 4;  // led mode in bits 5:4

   // status byte bits
   localparam int STAT_ARMED_BIT     = 0;
   localparam int STAT_TRIG_SEEN_BIT = 1;

   // upper part of the trigger level lives in its own byte
   localparam int TRIG_HI_WIDTH = adc_types_pkg::ADC_WIDTH - REG_DATA_WIDTH;

   // led mode encodings
   localparam adc_types_pkg::led_sel_t LED_MODE_STATE = 2'd0;
   localparam adc_types_pkg::led_sel_t LED_MODE_BEAT  = 2'd1;
   localparam adc_types_pkg::led_sel_t LED_MODE_ON    = 2'd2;
   localparam adc_types_pkg::led_sel_t LED_MODE_OFF   = 2'd3;

   typedef struct packed {
      adc_types_pkg::gain_t       gain;
      adc_types_pkg::adc_sample_t trig_level;
      logic                       arm;
      logic                       use_adc;
      adc_types_pkg::led_sel_t    led_select;
   } adc_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/adc_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module adc_reg_block (
   input  wire                            ADC_clk_sample,
   input  wire                            reset,
   input  wire adc_regmap_pkg::reg_addr_t reg_address_i,
   input  wire adc_regmap_pkg::reg_data_t reg_datai_i,
   input  wire                            reg_read_i,
   input  wire                            reg_write_i,
   input  wire                            trig_pulse_i,
   output adc_regmap_pkg::reg_data_t      reg_datao_o,
   output adc_regmap_pkg::adc_ctrl_t      ctrl_o
);

   import adc_regmap_pkg::*;

   reg_data_t                gain_reg;
   reg_data_t                settings_reg;  // full byte kept for readback
   reg_data_t                trig_lo_reg;
   logic [TRIG_HI_WIDTH-1:0] trig_hi_reg;
   logic                     trig_seen;     // sticky until settings are written
   reg_data_t                status;
   logic                     settings_wr;

   assign settings_wr = reg_write_i && (reg_address_i == REG_SETTINGS);

   // write decode, new value takes effect on the next cycle
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         gain_reg     <= '0;
         settings_reg <= '0;
         trig_lo_reg  <= '0;
         trig_hi_reg  <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            REG_GAIN:     gain_reg     <= reg_datai_i;
            REG_SETTINGS: settings_reg <= reg_datai_i;
            REG_TRIG_LO:  trig_lo_reg  <= reg_datai_i;
            REG_TRIG_HI:  trig_hi_reg  <= reg_datai_i[TRIG_HI_WIDTH-1:0];
            default: ;  // status and unused addresses ignore writes
         endcase
      end
   end

   // a pulse in the same cycle as the clear wins
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         trig_seen <= 1'b0;
      else if (trig_pulse_i)
         trig_seen <= 1'b1;
      else if (settings_wr)
         trig_seen <= 1'b0;
   end

   always_comb begin
      ctrl_o.gain       = gain_reg;
      ctrl_o.trig_level = {trig_hi_reg, trig_lo_reg};
      ctrl_o.arm        = settings_reg[SET_ARM_BIT];
      ctrl_o.use_adc    = settings_reg[SET_SRC_BIT];
      ctrl_o.led_select = settings_reg[SET_LED_LSB +: $bits(ctrl_o.led_select)];
   end

   always_comb begin
      status                     = '0;
      status[STAT_ARMED_BIT]     = settings_reg[SET_ARM_BIT];
      status[STAT_TRIG_SEEN_BIT] = trig_seen;
   end

   // read mux, zero when not reading
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            REG_GAIN:     reg_datao_o = gain_reg;
            REG_SETTINGS: reg_datao_o = settings_reg;
            REG_TRIG_LO:  reg_datao_o = trig_lo_reg;
            REG_TRIG_HI:  reg_datao_o = reg_data_t'(trig_hi_reg);
            REG_STATUS:   reg_datao_o = status;
            default:      reg_datao_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/adc_sample_source.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sample_source (
   input  wire                             ADC_clk_sample,
   input  wire                             reset,
   input  wire adc_types_pkg::adc_sample_t adc_data_i,
   input  wire                             use_adc_i,
   output adc_types_pkg::adc_sample_t      sample_o
);

   import adc_types_pkg::*;

   adc_sample_t test_count;  // free running ramp

   // wraps at 4096 on its own
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         test_count <= '0;
      else
         test_count <= test_count + 1'b1;
   end

   // one register stage from the pins in adc mode
   always_ff @(posedge ADC_clk_sample) begin
      if (use_adc_i)
         sample_o <= adc_data_i;
      else
         sample_o <= test_count;
   end

endmodule

`default_nettype wire

// File: rtl/adc_level_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module adc_level_trigger (
   input  wire                             ADC_clk_sample,
   input  wire                             reset,
   input  wire adc_types_pkg::adc_sample_t sample_i,
   input  wire adc_types_pkg::adc_sample_t trig_level_i,
   input  wire                             arm_i,
   output logic                            trigger_o
);

   import adc_types_pkg::*;

   logic arm_q;
   logic arm_rise;
   logic allowed;  // waiting for the level after an arm
   logic hit;

   assign arm_rise = arm_i && !arm_q;

   // level top bit picks the direction
   always_comb begin
      if (trig_level_i[ADC_WIDTH-1])
         hit = allowed && (sample_i > trig_level_i);  // fire above the level
      else
         hit = allowed && (sample_i < trig_level_i);  // fire below the level
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         arm_q     <= 1'b0;
         allowed   <= 1'b0;
         trigger_o <= 1'b0;
      end else begin
         arm_q     <= arm_i;
         trigger_o <= hit;
         // closing the window on the hit keeps the pulse one cycle wide
         if (hit)
            allowed <= 1'b0;
         else if (arm_rise)
            allowed <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/gain_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module gain_pwm (
   input  wire                       ADC_clk_sample,
   input  wire                       reset,
   input  wire adc_types_pkg::gain_t gain_i,
   output logic                      pwm_o
);

   import adc_types_pkg::*;

   logic [GAIN_WIDTH:0] acc;  // msb is the carry out

   // first order accumulator, carry density follows gain/256
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         acc <= '0;
      else
         acc <= {1'b0, acc[GAIN_WIDTH-1:0]} + {1'b0, gain_i};
   end

   assign pwm_o = acc[GAIN_WIDTH];

endmodule

`default_nettype wire

// File: rtl/led_status_mux.sv
`timescale 1ns/1ps
`default_nettype none

module led_status_mux #(
   parameter int pHEARTBEAT_BITS = 25
) (
   input  wire                          ADC_clk_sample,
   input  wire                          reset,
   input  wire adc_types_pkg::led_sel_t led_select_i,
   input  wire                          armed_i,
   input  wire                          trig_pulse_i,
   output logic                         led_armed_o,
   output logic                         led_capture_o
);

   import adc_regmap_pkg::*;

   logic [pHEARTBEAT_BITS-1:0] heartbeat;
   logic                       trig_toggle;  // flips once per trigger
   logic                       beat;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         heartbeat   <= '0;
         trig_toggle <= 1'b0;
      end else begin
         heartbeat <= heartbeat + 1'b1;
         if (trig_pulse_i)
            trig_toggle <= ~trig_toggle;
      end
   end

   assign beat = heartbeat[pHEARTBEAT_BITS-1];

   always_comb begin
      case (led_select_i)
         LED_MODE_STATE: begin
            led_armed_o   = armed_i;
            led_capture_o = trig_toggle;
         end
         LED_MODE_BEAT: begin  // alternate blink
            led_armed_o   = beat;
            led_capture_o = ~beat;
         end
         LED_MODE_ON: begin
            led_armed_o   = 1'b1;
            led_capture_o = 1'b1;
         end
         LED_MODE_OFF: begin
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
         default: begin
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/adc_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend_top #(
   parameter int pHEARTBEAT_BITS = 25
) (
   input  wire                             ADC_clk_sample,
   input  wire                             reset,
   input  wire adc_types_pkg::adc_sample_t adc_data_i,
   // register port
   input  wire adc_regmap_pkg::reg_addr_t  reg_address_i,
   input  wire adc_regmap_pkg::reg_data_t  reg_datai_i,
   input  wire                             reg_read_i,
   input  wire                             reg_write_i,
   output wire adc_regmap_pkg::reg_data_t  reg_datao_o,
   // data path and board outputs
   output wire adc_types_pkg::adc_sample_t sample_o,
   output wire                             trigger_adc_o,
   output wire                             armed_o,
   output wire                             amp_gain_o,
   output wire                             led_armed_o,
   output wire                             led_capture_o
);

   import adc_types_pkg::*;
   import adc_regmap_pkg::*;

   adc_ctrl_t   ctrl;
   adc_sample_t sample;
   logic        trig_pulse;

   adc_reg_block i_reg_block (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_datai_i    (reg_datai_i),
      .reg_read_i     (reg_read_i),
      .reg_write_i    (reg_write_i),
      .trig_pulse_i   (trig_pulse),
      .reg_datao_o    (reg_datao_o),
      .ctrl_o         (ctrl)
   );

   adc_sample_source i_sample_source (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .use_adc_i      (ctrl.use_adc),
      .sample_o       (sample)
   );

   adc_level_trigger i_level_trigger (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .sample_i       (sample),
      .trig_level_i   (ctrl.trig_level),
      .arm_i          (ctrl.arm),
      .trigger_o      (trig_pulse)
   );

   gain_pwm i_gain_pwm (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .gain_i         (ctrl.gain),
      .pwm_o          (amp_gain_o)
   );

   led_status_mux #(
      .pHEARTBEAT_BITS (pHEARTBEAT_BITS)
   ) i_led_status_mux (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .led_select_i   (ctrl.led_select),
      .armed_i        (ctrl.arm),
      .trig_pulse_i   (trig_pulse),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

   assign sample_o      = sample;
   assign trigger_adc_o = trig_pulse;
   assign armed_o       = ctrl.arm;  // arm bit straight from the settings register

endmodule

`default_nettype wire

// File: test/adc_frontend_props.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend_props (
   input wire                             ADC_clk_sample,
   input wire                             reset,
   input wire adc_types_pkg::adc_sample_t adc_data_i,
   input wire adc_regmap_pkg::reg_addr_t  reg_address_i,
   input wire adc_regmap_pkg::reg_data_t  reg_datai_i,
   input wire                             reg_write_i,
   input wire adc_types_pkg::adc_sample_t sample_i,
   input wire                             trigger_i,
   input wire                             armed_i,
   input wire                             led_armed_i,
   input wire                             led_capture_i
);

   import adc_types_pkg::*;
   import adc_regmap_pkg::*;

   int          fail_count = 0;
   logic        use_adc;     // shadow of the source bit
   led_sel_t    led_mode;
   adc_sample_t level;
   logic        armed_q;
   logic        pulse_seen;  // pulse since the last arm rise
   logic        level_hit;

   // register shadows from the write port
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         use_adc  <= 1'b0;
         led_mode <= '0;
         level    <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            REG_SETTINGS: begin
               use_adc  <= reg_datai_i[SET_SRC_BIT];
               led_mode <= reg_datai_i[SET_LED_LSB +: LED_SEL_WIDTH];
            end
            REG_TRIG_LO: level[REG_DATA_WIDTH-1:0] <= reg_datai_i;
            REG_TRIG_HI: level[ADC_WIDTH-1:REG_DATA_WIDTH] <= reg_datai_i[TRIG_HI_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         armed_q    <= 1'b0;
         pulse_seen <= 1'b0;
      end else begin
         armed_q <= armed_i;
         if (armed_i && !armed_q)
            pulse_seen <= 1'b0;  // new arm opens a new window
         else if (trigger_i)
            pulse_seen <= 1'b1;
      end
   end

   assign level_hit = level[ADC_WIDTH-1] ? (sample_i > level) : (sample_i < level);

   a_adc_path: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         use_adc |=> sample_i == $past(adc_data_i))
      else begin
         fail_count++;
         $error("sample_o does not follow adc_data_i");
      end

   a_counter_path: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         !use_adc && !$past(use_adc) && !$past(reset)
         |=> sample_i == adc_sample_t'($past(sample_i) + 1'b1))
      else begin
         fail_count++;
         $error("test counter sample did not step by one");
      end

   a_pulse_width: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         trigger_i |=> !trigger_i)
      else begin
         fail_count++;
         $error("trigger pulse longer than one cycle");
      end

   a_pulse_cause: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         trigger_i |-> $past(level_hit))
      else begin
         fail_count++;
         $error("trigger without a level crossing");
      end

   a_one_per_arm: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         trigger_i |-> !pulse_seen)
      else begin
         fail_count++;
         $error("second trigger pulse within one arm");
      end

   a_beat_leds: assert property (@(posedge ADC_clk_sample) disable iff (reset)
         led_mode == LED_MODE_BEAT |-> led_armed_i != led_capture_i)
      else begin
         fail_count++;
         $error("heartbeat leds not complementary");
      end

endmodule

bind adc_frontend_top adc_frontend_props i_props (
   .ADC_clk_sample (ADC_clk_sample),
   .reset          (reset),
   .adc_data_i     (adc_data_i),
   .reg_address_i  (reg_address_i),
   .reg_datai_i    (reg_datai_i),
   .reg_write_i    (reg_write_i),
   .sample_i       (sample_o),
   .trigger_i      (trigger_adc_o),
   .armed_i        (armed_o),
   .led_armed_i    (led_armed_o),
   .led_capture_i  (led_capture_o)
);

`default_nettype wire

// File: test/tb_adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_frontend;

   import adc_types_pkg::*;
   import adc_regmap_pkg::*;

   localparam int TIMEOUT_CYCLES = 5000;  // covers a full counter wrap

   logic        ADC_clk_sample = 1'b0;
   logic        reset;
   adc_sample_t adc_data_i = '0;
   reg_addr_t   reg_address_i;
   reg_data_t   reg_datai_i;
   logic        reg_read_i;
   logic        reg_write_i;
   reg_data_t   reg_datao_o;
   adc_sample_t sample_o;
   logic        trigger_adc_o;
   logic        armed_o;
   logic        amp_gain_o;
   logic        led_armed_o;
   logic        led_capture_o;
   integer      seed = 32'hdba0_6cc5;
   int          check_errors = 0;
   int          test_start = 0;

   always #4 ADC_clk_sample = ~ADC_clk_sample;

   always @(posedge ADC_clk_sample)
      adc_data_i <= adc_sample_t'($random(seed));  // converter noise

   adc_frontend_top #(.pHEARTBEAT_BITS(6)) i_dut (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .reg_address_i  (reg_address_i),
      .reg_datai_i    (reg_datai_i),
      .reg_read_i     (reg_read_i),
      .reg_write_i    (reg_write_i),
      .reg_datao_o    (reg_datao_o),
      .sample_o       (sample_o),
      .trigger_adc_o  (trigger_adc_o),
      .armed_o        (armed_o),
      .amp_gain_o     (amp_gain_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

   function automatic int total_errors();
      return check_errors + i_dut.i_props.fail_count;
   endfunction

   task automatic expect_equal(input string name, input int expected, input int actual);
      if (expected != actual) begin
         check_errors++;
         $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = total_errors() - test_start;
      if (errs == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errs);
      test_start = total_errors();
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      @(posedge ADC_clk_sample);
      reg_address_i <= addr;
      reg_datai_i   <= data;
      reg_write_i   <= 1'b1;
      @(posedge ADC_clk_sample);
      reg_write_i <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
      @(posedge ADC_clk_sample);
      reg_address_i <= addr;
      reg_read_i    <= 1'b1;
      @(negedge ADC_clk_sample);
      data = reg_datao_o;  // combinational read, stable mid cycle
      @(posedge ADC_clk_sample);
      reg_read_i <= 1'b0;
   endtask

   task automatic wait_trigger(input string name, output bit seen);
      int i;
      seen = 1'b0;
      for (i = 0; i < TIMEOUT_CYCLES && !seen; i++) begin
         @(negedge ADC_clk_sample);
         seen = trigger_adc_o;
      end
      if (!seen) begin
         check_errors++;
         $display("%s: no trigger pulse within %0d cycles", name, TIMEOUT_CYCLES);
      end
   endtask

   task automatic arm_trigger(input string name, input adc_sample_t level, input bit use_adc);
      reg_data_t status;
      bit        seen;
      write_reg(REG_SETTINGS, {6'd0, use_adc, 1'b0});
      write_reg(REG_TRIG_LO, level[7:0]);
      write_reg(REG_TRIG_HI, {4'd0, level[11:8]});
      write_reg(REG_SETTINGS, {6'd0, use_adc, 1'b1});
      if (use_adc) begin
         repeat (64) @(posedge ADC_clk_sample);  // random data may not cross the level
      end else begin
         wait_trigger(name, seen);
         if (seen) begin
            read_reg(REG_STATUS, status);
            expect_equal(name, (1 << STAT_ARMED_BIT) | (1 << STAT_TRIG_SEEN_BIT), int'(status));
         end
      end
      write_reg(REG_SETTINGS, {6'd0, use_adc, 1'b0});
   endtask

   task automatic check_pwm(input reg_data_t gain);
      int high;
      high = 0;
      write_reg(REG_GAIN, gain);
      repeat (256) @(posedge ADC_clk_sample);  // let the accumulator settle
      repeat (256) begin
         @(negedge ADC_clk_sample);
         if (amp_gain_o)
            high++;
      end
      expect_equal($sformatf("pwm gain %0d", gain), int'(gain), high);
   endtask

   task automatic count_led_toggles(output int armed_flips, output int capture_flips);
      logic armed_prev;
      logic capture_prev;
      armed_flips   = 0;
      capture_flips = 0;
      @(negedge ADC_clk_sample);
      armed_prev   = led_armed_o;
      capture_prev = led_capture_o;
      repeat (256) begin
         @(negedge ADC_clk_sample);
         if (led_armed_o != armed_prev)
            armed_flips++;
         if (led_capture_o != capture_prev)
            capture_flips++;
         armed_prev   = led_armed_o;
         capture_prev = led_capture_o;
      end
   endtask

   initial begin
      reg_data_t rd;
      bit        seen;
      logic      toggle_prev;
      int        a_flips;
      int        c_flips;
      reset         = 1'b1;
      reg_address_i = '0;
      reg_datai_i   = '0;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      repeat (5) @(posedge ADC_clk_sample);
      reset <= 1'b0;

      write_reg(REG_GAIN, 8'hA5);
      write_reg(REG_TRIG_LO, 8'h5A);
      write_reg(REG_TRIG_HI, 8'hFC);
      write_reg(REG_SETTINGS, 8'h33);  // arm, adc pins, led mode 3
      read_reg(REG_GAIN, rd);
      expect_equal("read gain", 'hA5, int'(rd));
      read_reg(REG_SETTINGS, rd);
      expect_equal("read settings", 'h33, int'(rd));
      read_reg(REG_TRIG_LO, rd);
      expect_equal("read trig lo", 'h5A, int'(rd));
      read_reg(REG_TRIG_HI, rd);
      expect_equal("read trig hi", 'h0C, int'(rd));  // only 4 bits kept
      read_reg(REG_STATUS, rd);
      expect_equal("status armed", 1, int'(rd[STAT_ARMED_BIT]));
      read_reg(8'h07, rd);
      expect_equal("read unused", 0, int'(rd));
      report_test("register_readback");

      write_reg(REG_SETTINGS, 8'h02);
      repeat (300) @(posedge ADC_clk_sample);
      write_reg(REG_SETTINGS, 8'h00);
      repeat (4200) @(posedge ADC_clk_sample);  // through a counter wrap
      report_test("sample_source");

      // adc runs first so the counter runs end with the trigger consumed
      arm_trigger("trig adc above", 12'hE00, 1'b1);
      arm_trigger("trig adc below", 12'h100, 1'b1);
      arm_trigger("trig count above", 12'h900, 1'b0);
      arm_trigger("trig count below", 12'h300, 1'b0);
      report_test("level_trigger");

      check_pwm(8'd0);
      check_pwm(8'd1);
      check_pwm(8'd128);
      check_pwm(8'd255);
      report_test("gain_pwm");

      write_reg(REG_TRIG_LO, 8'h00);
      write_reg(REG_TRIG_HI, 8'h08);
      write_reg(REG_SETTINGS, 8'h01);  // mode 0, armed
      @(negedge ADC_clk_sample);
      expect_equal("armed out on", 1, int'(armed_o));
      expect_equal("led mode0 armed on", 1, int'(led_armed_o));
      toggle_prev = led_capture_o;
      wait_trigger("led mode0 trigger", seen);
      @(negedge ADC_clk_sample);
      if (seen)
         expect_equal("led mode0 toggle", int'(!toggle_prev), int'(led_capture_o));
      write_reg(REG_SETTINGS, 8'h00);
      @(negedge ADC_clk_sample);
      expect_equal("armed out off", 0, int'(armed_o));
      expect_equal("led mode0 armed off", 0, int'(led_armed_o));

      write_reg(REG_SETTINGS, 8'h10);
      count_led_toggles(a_flips, c_flips);
      if (a_flips < 4 || c_flips < 4) begin
         check_errors++;
         $display("heartbeat leds toggled %0d and %0d times in 256 cycles", a_flips, c_flips);
      end
      write_reg(REG_SETTINGS, 8'h20);
      @(negedge ADC_clk_sample);
      expect_equal("led mode2", 'b11, int'({led_armed_o, led_capture_o}));
      write_reg(REG_SETTINGS, 8'h30);
      @(negedge ADC_clk_sample);
      expect_equal("led mode3", 'b00, int'({led_armed_o, led_capture_o}));
      report_test("led_modes");

      $display("errors: %0d check, %0d assertion", check_errors, i_dut.i_props.fail_count);
      if (total_errors() == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
rtl/adc_types_pkg.sv
rtl/adc_regmap_pkg.sv
rtl/adc_reg_block.sv
rtl/adc_sample_source.sv
rtl/adc_level_trigger.sv
rtl/gain_pwm.sv
rtl/led_status_mux.sv
rtl/adc_frontend_top.sv
test/adc_frontend_props.sv
test/tb_adc_frontend.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_adc_frontend -f list.f -o tb_sim

./obj_dir/tb_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
